// ==== files.f ====
+incdir+src
src/adc_sbc_pkg.sv
src/xotr_sequencer.sv
src/decoder_op_xotr_01xxx010.sv
src/alu16_adc_sbc.sv
src/register_pair_file.sv
src/adc_sbc_hl_top.sv
tests/adc_sbc_hl_sva.sv
tests/tb_adc_sbc_hl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_adc_sbc_hl -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_adc_sbc_hl > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0

// ==== src/adc_sbc_hl_top.sv ====
// ADC/SBC HL,ss execution group. The opcode is assumed to be from 01xxx010
// after the ED prefix; one instruction at a time, no back-pressure.
`default_nettype none

module adc_sbc_hl_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire adc_sbc_pkg::byte_t     opcode,
    input  wire logic                   load,
    input  wire adc_sbc_pkg::pair_sel_t load_sel,
    input  wire adc_sbc_pkg::word_t     load_value,
    input  wire logic                   load_f,
    input  wire adc_sbc_pkg::byte_t     load_flags,
    output logic                        busy,
    output logic                        done,
    output adc_sbc_pkg::word_t          hl,
    output adc_sbc_pkg::byte_t          flags
);

    import adc_sbc_pkg::*;

    xpt_t       xpt;
    logic       run_enable;
    byte_t      src_byte;
    xotr_ctrl_t ctrl;
    alu_out_t   alu;
    word_t      pair_value;
    logic       carry_in;

    xotr_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .opcode     (opcode),
        .op_end     (ctrl.op_end),
        .xpt        (xpt),
        .run_enable (run_enable),
        .src_byte   (src_byte),
        .busy       (busy)
    );

    decoder_op_xotr_01xxx010 u_dec (
        .enable (run_enable),
        .xpt    (xpt),
        .source (src_byte),
        .ctrl   (ctrl),
        .done   (done)
    );

    alu16_adc_sbc u_alu (
        .a        (hl),
        .b        (pair_value),
        .carry_in (carry_in),
        .subtract (ctrl.subtract),
        .alu      (alu)
    );

    register_pair_file u_regs (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .load       (load),
        .load_sel   (load_sel),
        .load_value (load_value),
        .load_f     (load_f),
        .load_flags (load_flags),
        .ctrl       (ctrl),
        .alu        (alu),
        .hl_value   (hl),
        .pair_value (pair_value),
        .carry_in   (carry_in),
        .flags      (flags)
    );

endmodule

`default_nettype wire

// ==== src/adc_sbc_pkg.sv ====
// Shared types for the ADC/SBC HL,ss group. The XPT width comes from the settings header.
`default_nettype none

`include "adc_sbc_settings.svh"

package adc_sbc_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0] byte_t;
    typedef logic [`XPT_W-1:0] xpt_t;

    // Pair code from opcode bits 5:4. Code 3 is SP, not AF.
    typedef logic [1:0] pair_sel_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    // Control strobes from the decoder.
    typedef struct packed {
        logic      hl_write;
        logic      flag_write;
        logic      subtract;
        pair_sel_t pair_sel;
        logic      op_end;
    } xotr_ctrl_t;

    typedef struct packed {
        word_t result;
        byte_t flags;
    } alu_out_t;

endpackage

`default_nettype wire

// ==== src/adc_sbc_settings.svh ====
// XPT step numbers of ADC/SBC HL,ss. They are fixed by the instruction
// timing and are not meant to be tuned.
`ifndef ADC_SBC_SETTINGS_SVH
`define ADC_SBC_SETTINGS_SVH

// ====================
// XPT counter
// ====================

// Width of the XPT state counter.
`define XPT_W 5

// Step at which HL and F are written from the ALU.
`define XPT_WRITE_STEP 4

// Step at which the instruction ends and done is raised.
`define XPT_END_STEP 10

`endif

// ==== src/alu16_adc_sbc.sv ====
// Combinational 16-bit ADC/SBC with full Z80 flags, including F bits 5 and 3.
// Subtraction is done as addition of the inverted operand and carry.
`default_nettype none

module alu16_adc_sbc (
    input  wire adc_sbc_pkg::word_t a,
    input  wire adc_sbc_pkg::word_t b,
    input  wire logic               carry_in,
    input  wire logic               subtract,
    output adc_sbc_pkg::alu_out_t   alu
);

    import adc_sbc_pkg::*;

    word_t       b_eff;
    logic        c_eff;
    logic [16:0] sum;
    logic [12:0] low_sum;
    word_t       result;
    logic        half;
    logic        carry;
    logic        overflow;

    // ====================
    // Adder
    // ====================

    // a - b - c is a + ~b + ~c, with the carry outs inverted to borrows.
    assign b_eff = subtract ? ~b : b;
    assign c_eff = subtract ? ~carry_in : carry_in;

    assign sum     = {1'b0, a} + {1'b0, b_eff} + {16'd0, c_eff};
    assign low_sum = {1'b0, a[11:0]} + {1'b0, b_eff[11:0]} + {12'd0, c_eff};

    assign result = sum[15:0];
    assign carry  = sum[16] ^ subtract;
    assign half   = low_sum[12] ^ subtract;

    // Signed overflow: both effective operands agree in sign and the result does not.
    assign overflow = (a[15] == b_eff[15]) && (result[15] != a[15]);

    // ====================
    // Flag byte
    // ====================

    always_comb begin
        alu.result   = result;
        alu.flags[7] = result[15];
        alu.flags[6] = (result == 16'h0000);
        alu.flags[5] = result[13];
        alu.flags[4] = half;
        alu.flags[3] = result[11];
        alu.flags[2] = overflow;
        alu.flags[1] = subtract;
        alu.flags[0] = carry;
    end

endmodule

`default_nettype wire

// ==== src/decoder_op_xotr_01xxx010.sv ====
// Decodes ADC/SBC HL,ss from the XPT state and the latched opcode. Bits 7:6
// and 2:0 of the opcode are assumed to be 01 and 010 and are not checked.
`default_nettype none

`include "adc_sbc_settings.svh"

module decoder_op_xotr_01xxx010 (
    input  wire logic               enable,
    input  wire adc_sbc_pkg::xpt_t  xpt,
    input  wire adc_sbc_pkg::byte_t source,
    output adc_sbc_pkg::xotr_ctrl_t ctrl,
    output logic                    done
);

    import adc_sbc_pkg::*;

    logic write_step;
    logic end_step;

    // ====================
    // XPT decode
    // ====================

    assign write_step = enable && (xpt == xpt_t'(`XPT_WRITE_STEP));
    assign end_step   = enable && (xpt == xpt_t'(`XPT_END_STEP));

    // ====================
    // Control strobes
    // ====================

    always_comb begin
        ctrl = '0;

        if (write_step) begin
            ctrl.hl_write   = 1'b1;
            ctrl.flag_write = 1'b1;
            // Bit 3 set is ADC, clear is SBC.
            ctrl.subtract   = ~source[3];
            ctrl.pair_sel   = source[5:4];
        end

        // End of the instruction; the sequencer resets XPT on this.
        ctrl.op_end = end_step;
    end

    assign done = ctrl.op_end;

endmodule

`default_nettype wire

// ==== src/register_pair_file.sv ====
// Holds BC, DE, HL, SP and F. External loads are dropped while an instruction
// runs; the instruction write takes precedence over any load.
`default_nettype none

module register_pair_file (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    busy,
    input  wire logic                    load,
    input  wire adc_sbc_pkg::pair_sel_t  load_sel,
    input  wire adc_sbc_pkg::word_t      load_value,
    input  wire logic                    load_f,
    input  wire adc_sbc_pkg::byte_t      load_flags,
    input  wire adc_sbc_pkg::xotr_ctrl_t ctrl,
    input  wire adc_sbc_pkg::alu_out_t   alu,
    output adc_sbc_pkg::word_t           hl_value,
    output adc_sbc_pkg::word_t           pair_value,
    output logic                         carry_in,
    output adc_sbc_pkg::byte_t           flags
);

    import adc_sbc_pkg::*;

    // Index 0 BC, 1 DE, 2 HL, 3 SP.
    word_t pairs [4];
    byte_t f_reg;

    // ====================
    // Pair registers
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                pairs[i] <= '0;
            end
        end else if (ctrl.hl_write) begin
            pairs[2] <= alu.result;
        end else if (load && !busy) begin
            pairs[load_sel] <= load_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            f_reg <= '0;
        end else if (ctrl.flag_write) begin
            f_reg <= alu.flags;
        end else if (load_f && !busy) begin
            f_reg <= load_flags;
        end
    end

    // ====================
    // Read side
    // ====================

    assign hl_value   = pairs[2];
    assign pair_value = pairs[ctrl.pair_sel];
    assign carry_in   = f_reg[0];
    assign flags      = f_reg;

endmodule

`default_nettype wire

// ==== src/xotr_sequencer.sv ====
// Steps the XPT counter of one ED-prefixed instruction. Start is ignored while
// busy, and the end step is known only through op_end from the decoder.
`default_nettype none

`include "adc_sbc_settings.svh"

module xotr_sequencer (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire adc_sbc_pkg::byte_t opcode,
    input  wire logic               op_end,
    output adc_sbc_pkg::xpt_t       xpt,
    output logic                    run_enable,
    output adc_sbc_pkg::byte_t      src_byte,
    output logic                    busy
);

    import adc_sbc_pkg::*;

    seq_state_t state;

    // ====================
    // State and counter
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            xpt   <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_RUN;
                        xpt   <= '0;
                    end
                end
                SEQ_RUN: begin
                    if (op_end) begin
                        state <= SEQ_IDLE;
                        xpt   <= '0;
                    end else begin
                        xpt <= xpt + {{(`XPT_W - 1){1'b0}}, 1'b1};
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // The opcode byte is held for the whole instruction.
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && start) begin
            src_byte <= opcode;
        end
    end

    assign run_enable = (state == SEQ_RUN);
    assign busy       = (state == SEQ_RUN);

endmodule

`default_nettype wire

// ==== tests/adc_sbc_hl_sva.sv ====
// Protocol checks on the XPT sequencer, bound into xotr_sequencer.
// The end step is taken from the settings header.
`default_nettype none

`include "adc_sbc_settings.svh"

module adc_sbc_hl_sva (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              start,
    input wire logic              op_end,
    input wire logic              busy,
    input wire adc_sbc_pkg::xpt_t xpt
);

    import adc_sbc_pkg::*;

    // XPT never runs past the end step.
    a_xpt_range: assert property (@(posedge clk) disable iff (rst)
        xpt <= xpt_t'(`XPT_END_STEP))
        else $error("xpt exceeded the end step");

    a_start: assert property (@(posedge clk) disable iff (rst)
        start && !busy |=> busy && xpt == '0)
        else $error("start while idle did not begin at xpt 0");

    a_step: assert property (@(posedge clk) disable iff (rst)
        busy && !op_end |=> busy && xpt == $past(xpt) + xpt_t'(1))
        else $error("xpt did not advance by one");

    // The end strobe comes one cycle after the counter has stepped through the end step.
    a_end_step: assert property (@(posedge clk) disable iff (rst)
        start && !busy |-> ##(`XPT_END_STEP + 1) op_end)
        else $error("op_end did not come at the end step after start");

    a_end_idle: assert property (@(posedge clk) disable iff (rst)
        op_end |=> !busy)
        else $error("busy stayed high after op_end");

    a_idle_xpt: assert property (@(posedge clk) disable iff (rst)
        !busy |-> xpt == '0)
        else $error("xpt not cleared while idle");

endmodule

`default_nettype wire

// ==== tests/tb_adc_sbc_hl.sv ====
// Testbench for ADC/SBC HL,ss. Operands come from a 16-bit LFSR with a fixed
// seed; each instruction is checked against a flag model after done.
`default_nettype none

module tb_adc_sbc_hl;

    import adc_sbc_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int N_OPS         = 38;
    localparam int CYCLES_PER_OP = 20;
    localparam int MAX_WAIT      = 20;

    logic      clk = 1'b0;
    logic      rst;
    logic      start;
    byte_t     opcode;
    logic      load;
    pair_sel_t load_sel;
    word_t     load_value;
    logic      load_f;
    byte_t     load_flags;
    logic      busy;
    logic      done;
    word_t     hl;
    byte_t     flags;

    int          value_errors = 0;
    int          other_errors = 0;
    logic [15:0] lfsr = 16'd45695;

    adc_sbc_hl_top dut (.*);

    bind xotr_sequencer adc_sbc_hl_sva u_sva (
        .clk(clk), .rst(rst), .start(start), .op_end(op_end), .busy(busy), .xpt(xpt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // Result and F byte as the Z80 defines them for ADC/SBC HL,ss.
    function automatic logic [23:0] expected_alu(input logic [15:0] hl_v, input logic [15:0] ss_v,
                                                 input logic c, input logic sub);
        logic [16:0] full;
        logic [15:0] r;
        logic        half;
        logic        ovf;
        if (!sub) begin
            full = {1'b0, hl_v} + {1'b0, ss_v} + {16'd0, c};
            half = ({1'b0, hl_v[11:0]} + {1'b0, ss_v[11:0]} + {12'd0, c}) > 13'h0FFF;
            r    = full[15:0];
            ovf  = (hl_v[15] == ss_v[15]) && (r[15] != hl_v[15]);
        end else begin
            full = {1'b0, hl_v} - {1'b0, ss_v} - {16'd0, c};
            half = {1'b0, hl_v[11:0]} < ({1'b0, ss_v[11:0]} + {12'd0, c});
            r    = full[15:0];
            ovf  = (hl_v[15] != ss_v[15]) && (r[15] != hl_v[15]);
        end
        return {r, r[15], (r == 16'd0), r[13], half, r[11], ovf, sub, full[16]};
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic load_regs(input word_t hl_v, input pair_sel_t sel, input word_t ss_v,
                             input byte_t f_v);
        @(posedge clk);
        load       <= 1'b1;
        load_sel   <= 2'd2;
        load_value <= hl_v;
        load_f     <= 1'b1;
        load_flags <= f_v;
        @(posedge clk);
        load       <= (sel != 2'd2);
        load_sel   <= sel;
        load_value <= ss_v;
        load_f     <= 1'b0;
        @(posedge clk);
        load <= 1'b0;
    endtask

    // Runs one instruction; with disturb set a start and loads arrive mid-flight.
    task automatic run_op(input byte_t op, input logic disturb, input word_t exp_hl,
                          input byte_t exp_f);
        int   cycles;
        logic seen_done;
        cycles    = 0;
        seen_done = 1'b0;
        @(posedge clk);
        start  <= 1'b1;
        opcode <= op;
        @(negedge clk);
        check_value("busy", 16'd0, 16'(busy));
        while (!seen_done && cycles < MAX_WAIT) begin
            @(posedge clk);
            start      <= disturb && cycles == 3;
            load       <= disturb && cycles == 3;
            load_f     <= disturb && cycles == 3;
            load_sel   <= 2'd2;
            load_value <= ~exp_hl;
            load_flags <= ~exp_f;
            opcode     <= op ^ 8'h08;
            cycles++;
            @(negedge clk);
            check_value("busy", 16'd1, 16'(busy));
            seen_done = done;
        end
        if (!seen_done) begin
            other_errors++;
            $display("ERROR t=%0t: done did not come within %0d cycles", $time, MAX_WAIT);
        end else begin
            check_value("start_to_done_cycles", 16'd11, 16'(cycles));
        end
        @(posedge clk);
        @(negedge clk);
        check_value("busy", 16'd0, 16'(busy));
        check_value("done", 16'd0, 16'(done));
        check_value("hl", exp_hl, hl);
        check_value("flags", 16'(exp_f), 16'(flags));
        if (disturb) begin
            repeat (MAX_WAIT) begin
                @(negedge clk);
                check_value("done", 16'd0, 16'(done));
            end
        end
    endtask

    task automatic exec_case(input pair_sel_t sel, input logic sub, input word_t hl_v,
                             input word_t ss_v, input logic c, input logic disturb);
        word_t       operand;
        logic [23:0] expv;
        logic [15:0] rnd;
        operand = (sel == 2'd2) ? hl_v : ss_v;
        expv    = expected_alu(hl_v, operand, c, sub);
        rand_bits(7, rnd);
        load_regs(hl_v, sel, ss_v, {rnd[6:0], c});
        run_op({2'b01, sel, ~sub, 3'b010}, disturb, expv[23:8], expv[7:0]);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] cbit;
        rst        <= 1'b1;
        start      <= 1'b0;
        opcode     <= '0;
        load       <= 1'b0;
        load_sel   <= '0;
        load_value <= '0;
        load_f     <= 1'b0;
        load_flags <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", 16'd0, 16'(busy));
        check_value("done", 16'd0, 16'(done));
        check_value("hl", 16'd0, hl);
        check_value("flags", 16'd0, 16'(flags));

        for (int sub = 0; sub < 2; sub++) begin
            for (int sel = 0; sel < 4; sel++) begin
                repeat (4) begin
                    rand_bits(16, a);
                    rand_bits(16, b);
                    rand_bits(1, cbit);
                    exec_case(pair_sel_t'(sel), sub[0], a, b, cbit[0], 1'b0);
                end
            end
        end

        // HL minus itself gives zero without carry and FFFF with a borrow.
        rand_bits(16, a);
        exec_case(2'd2, 1'b1, a, 16'h0000, 1'b0, 1'b0);
        exec_case(2'd2, 1'b1, a, 16'h0000, 1'b1, 1'b0);

        rand_bits(16, a);
        rand_bits(16, b);
        exec_case(2'd0, 1'b0, a, b, 1'b1, 1'b1);

        exec_case(2'd1, 1'b0, 16'h7FFF, 16'h0001, 1'b0, 1'b0);
        exec_case(2'd1, 1'b1, 16'h8000, 16'h0001, 1'b0, 1'b0);
        exec_case(2'd1, 1'b0, 16'hFFFF, 16'h0000, 1'b1, 1'b0);

        $display("errors: value=%0d other=%0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #((N_OPS * CYCLES_PER_OP + 100) * CLK_PERIOD);
        other_errors++;
        $display("ERROR: simulation did not finish within the time limit");
        $display("errors: value=%0d other=%0d", value_errors, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
